// ==== wl_pkg.sv ====
////////////////////////////////////////////////////////////
// Address map, widths, buffer depths and bus structs.
// Regions are word addressed; the low two address bits are ignored.
// Response credit counters wrap if more than 255 are granted.
////////////////////////////////////////////////////////////

package wl_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and base types
  ////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  localparam addr_t InstrMemBaseAddr = 32'h0000_1000;
  localparam addr_t InstrMemSize     = 32'h0000_0400;
  localparam addr_t DataMemBaseAddr  = 32'h0000_2000;
  localparam addr_t DataMemSize      = 32'h0000_0400;
  localparam addr_t CsrBaseAddr      = 32'h0000_3000;
  localparam int unsigned CsrNumRegs = 4;
  localparam addr_t CsrSize          = CsrNumRegs * 4;

  // Word index widths inside each region
  localparam int unsigned InstrMemAddrWidth = $clog2(InstrMemSize / 4);
  localparam int unsigned DataMemAddrWidth  = $clog2(DataMemSize / 4);
  localparam int unsigned CsrIdxWidth       = $clog2(CsrNumRegs);

  typedef logic [InstrMemAddrWidth-1:0] instr_idx_t;
  typedef logic [DataMemAddrWidth-1:0]  data_idx_t;

  ////////////////////////////////////////////////////////////
  // Flow control
  ////////////////////////////////////////////////////////////

  // Receive buffer depths, equal to the sender's initial credits
  localparam int unsigned HostReqDepth  = 2;
  localparam int unsigned FetchReqDepth = 2;

  localparam int unsigned RspCreditWidth = 8;
  typedef logic [RspCreditWidth-1:0] credit_cnt_t;

  ////////////////////////////////////////////////////////////
  // Request and response structs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
  } host_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } host_rsp_t;

  typedef struct packed {
    data_t instr;
  } fetch_rsp_t;

  // Target answer back to the decoder
  typedef struct packed {
    data_t rdata;
    logic  valid;
  } tgt_rsp_t;

endpackage

// ==== credit_rx_fifo.sv ====
////////////////////////////////////////////////////////////
// Receive buffer for a credit-based stream.
// The sender must hold a credit per push; overflow is not checked.
// One credit pulse is returned the cycle after each pop.
////////////////////////////////////////////////////////////

module credit_rx_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     credit_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     pop_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  payload_t mem_q [Depth];
  ptr_t     wr_ptr_q, rd_ptr_q;
  cnt_t     count_q;
  logic     credit_q;
  logic     do_pop;

  // Wrap at Depth, which need not be a power of two
  function automatic ptr_t ptr_inc(ptr_t ptr);
    if (ptr == ptr_t'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign valid_o  = (count_q != '0);
  assign data_o   = mem_q[rd_ptr_q];
  assign do_pop   = pop_i && valid_o;
  assign credit_o = credit_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q  <= count_q + cnt_t'(push_i) - cnt_t'(do_pop);
      credit_q <= do_pop;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== bus_decoder.sv ====
////////////////////////////////////////////////////////////
// Routes host requests by address, one request in flight.
// Unmapped addresses answer error 1, data 0. Forwarded requests
// carry the offset inside the target region.
////////////////////////////////////////////////////////////

module bus_decoder import wl_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      req_valid_i,
  input  host_req_t req_i,
  output logic      req_pop_o,
  output host_req_t imem_req_o,
  output host_req_t dmem_req_o,
  output host_req_t csr_req_o,
  output logic      imem_strb_o,
  output logic      dmem_strb_o,
  output logic      csr_strb_o,
  input  tgt_rsp_t  imem_rsp_i,
  input  tgt_rsp_t  dmem_rsp_i,
  input  tgt_rsp_t  csr_rsp_i,
  input  logic      rsp_credit_i,
  output logic      rsp_valid_o,
  output host_rsp_t rsp_o
);

  typedef enum logic [1:0] {StIdle, StBusy, StHold} state_e;
  typedef enum logic [1:0] {SelImem, SelDmem, SelCsr} sel_e;

  state_e      state_q, state_d;
  sel_e        sel_q, sel_d;
  host_rsp_t   rsp_q, rsp_d;
  credit_cnt_t cnt_q;
  logic        hit_imem, hit_dmem, hit_csr;
  tgt_rsp_t    sel_rsp;
  logic        send;

  function automatic logic in_region(addr_t addr, addr_t base, addr_t size);
    return (addr >= base) && (addr < base + size);
  endfunction

  ////////////////////////////////////////////////////////////
  // Address decode and forwarding
  ////////////////////////////////////////////////////////////

  assign hit_imem = in_region(req_i.addr, InstrMemBaseAddr, InstrMemSize);
  assign hit_dmem = in_region(req_i.addr, DataMemBaseAddr, DataMemSize);
  assign hit_csr  = in_region(req_i.addr, CsrBaseAddr, CsrSize);

  // Only pop when nothing is outstanding
  assign req_pop_o   = (state_q == StIdle) && req_valid_i;
  assign imem_strb_o = req_pop_o && hit_imem;
  assign dmem_strb_o = req_pop_o && hit_dmem;
  assign csr_strb_o  = req_pop_o && hit_csr;

  always_comb begin
    imem_req_o      = req_i;
    imem_req_o.addr = req_i.addr - InstrMemBaseAddr;
    dmem_req_o      = req_i;
    dmem_req_o.addr = req_i.addr - DataMemBaseAddr;
    csr_req_o       = req_i;
    csr_req_o.addr  = req_i.addr - CsrBaseAddr;
  end

  always_comb begin
    case (sel_q)
      SelImem: sel_rsp = imem_rsp_i;
      SelDmem: sel_rsp = dmem_rsp_i;
      default: sel_rsp = csr_rsp_i;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Transaction FSM
  ////////////////////////////////////////////////////////////

  assign send        = (state_q == StHold) && (cnt_q != '0);
  assign rsp_valid_o = send;
  assign rsp_o       = rsp_q;

  always_comb begin
    state_d = state_q;
    sel_d   = sel_q;
    rsp_d   = rsp_q;
    case (state_q)
      StIdle: begin
        if (req_valid_i) begin
          state_d = StBusy;
          if (hit_imem) begin
            sel_d = SelImem;
          end else if (hit_dmem) begin
            sel_d = SelDmem;
          end else if (hit_csr) begin
            sel_d = SelCsr;
          end else begin
            // Unmapped, answer right away
            rsp_d   = '{rdata: '0, error: 1'b1};
            state_d = StHold;
          end
        end
      end
      StBusy: begin
        if (sel_rsp.valid) begin
          rsp_d   = '{rdata: sel_rsp.rdata, error: 1'b0};
          state_d = StHold;
        end
      end
      StHold: begin
        if (send) begin
          state_d = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= StIdle;
      sel_q   <= SelImem;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      sel_q   <= sel_d;
      cnt_q   <= cnt_q + credit_cnt_t'(rsp_credit_i) - credit_cnt_t'(send);
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_q <= rsp_d;
  end

endmodule

// ==== instr_mem.sv ====
////////////////////////////////////////////////////////////
// Instruction memory, one read port shared by fetch and host.
// Fetch wins the port; a host read waits for a free cycle.
// Fetch addresses must lie in the instruction region.
////////////////////////////////////////////////////////////

module instr_mem import wl_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       fetch_valid_i,
  input  addr_t      fetch_addr_i,
  output logic       fetch_pop_o,
  input  logic       fetch_rsp_credit_i,
  output logic       fetch_rsp_valid_o,
  output fetch_rsp_t fetch_rsp_o,
  input  logic       host_strb_i,
  input  host_req_t  host_req_i,
  output tgt_rsp_t   host_rsp_o
);

  data_t       mem_q [2**InstrMemAddrWidth];
  addr_t       fetch_off;
  instr_idx_t  fetch_idx, host_idx, rd_idx, host_rd_idx_q;
  credit_cnt_t fcnt_q;
  logic        fetch_issue, host_issue;
  logic        host_rd_pend_q, host_rd_vld_q, host_wr_ack_q, fetch_vld_q;
  data_t       rd_data_q;

  assign fetch_off = fetch_addr_i - InstrMemBaseAddr;
  assign fetch_idx = fetch_off[InstrMemAddrWidth+1:2];
  assign host_idx  = host_req_i.addr[InstrMemAddrWidth+1:2];

  ////////////////////////////////////////////////////////////
  // Read port arbitration
  ////////////////////////////////////////////////////////////

  // Fetch needs a buffered address and a response credit
  assign fetch_issue = fetch_valid_i && (fcnt_q != '0);
  assign host_issue  = host_rd_pend_q && !fetch_issue;
  assign rd_idx      = fetch_issue ? fetch_idx : host_rd_idx_q;
  assign fetch_pop_o = fetch_issue;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fcnt_q         <= '0;
      host_rd_pend_q <= 1'b0;
      host_rd_vld_q  <= 1'b0;
      host_wr_ack_q  <= 1'b0;
      fetch_vld_q    <= 1'b0;
    end else begin
      // Credit is consumed at issue time
      fcnt_q        <= fcnt_q + credit_cnt_t'(fetch_rsp_credit_i)
                     - credit_cnt_t'(fetch_issue);
      fetch_vld_q   <= fetch_issue;
      host_rd_vld_q <= host_issue;
      host_wr_ack_q <= host_strb_i && host_req_i.write;
      if (host_strb_i && !host_req_i.write) begin
        host_rd_pend_q <= 1'b1;
      end else if (host_issue) begin
        host_rd_pend_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (host_strb_i && host_req_i.write) begin
      mem_q[host_idx] <= host_req_i.wdata;
    end
    if (host_strb_i && !host_req_i.write) begin
      host_rd_idx_q <= host_idx;
    end
    if (fetch_issue || host_issue) begin
      rd_data_q <= mem_q[rd_idx];
    end
  end

  assign fetch_rsp_valid_o = fetch_vld_q;
  assign fetch_rsp_o.instr = rd_data_q;

  // Writes ack with zero data
  assign host_rsp_o.valid = host_rd_vld_q || host_wr_ack_q;
  assign host_rsp_o.rdata = host_rd_vld_q ? rd_data_q : '0;

endmodule

// ==== data_mem.sv ====
////////////////////////////////////////////////////////////
// Data memory, single port, answers one cycle after a strobe.
// Addresses are region offsets; contents are not reset.
////////////////////////////////////////////////////////////

module data_mem import wl_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      strb_i,
  input  host_req_t req_i,
  output tgt_rsp_t  rsp_o
);

  data_t     mem_q [2**DataMemAddrWidth];
  data_idx_t idx;
  data_t     rd_q;
  logic      ack_q;

  assign idx = req_i.addr[DataMemAddrWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= strb_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (strb_i) begin
      if (req_i.write) begin
        mem_q[idx] <= req_i.wdata;
        rd_q       <= '0;
      end else begin
        rd_q <= mem_q[idx];
      end
    end
  end

  assign rsp_o.valid = ack_q;
  assign rsp_o.rdata = rd_q;

endmodule

// ==== csr_regfile.sv ====
////////////////////////////////////////////////////////////
// Control registers, all cleared on reset.
// Register 0 holds the end-of-computation value.
////////////////////////////////////////////////////////////

module csr_regfile import wl_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      strb_i,
  input  host_req_t req_i,
  output tgt_rsp_t  rsp_o,
  output data_t     eoc_o
);

  data_t                  regs_q [CsrNumRegs];
  logic [CsrIdxWidth-1:0] idx;
  data_t                  rd_q;
  logic                   ack_q;

  assign idx = req_i.addr[CsrIdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      for (int i = 0; i < CsrNumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      ack_q <= strb_i;
      if (strb_i && req_i.write) begin
        regs_q[idx] <= req_i.wdata;
      end
    end
  end

  // Read data, zero for writes
  always_ff @(posedge clk_i) begin
    if (strb_i) begin
      rd_q <= req_i.write ? '0 : regs_q[idx];
    end
  end

  assign rsp_o.valid = ack_q;
  assign rsp_o.rdata = rd_q;
  assign eoc_o       = regs_q[0];

endmodule

// ==== wl_top.sv ====
////////////////////////////////////////////////////////////
// Reduced tile interconnect: host port to imem, dmem and CSRs,
// plus a core fetch port into the instruction memory.
// All streams use credits; the sender starts with the buffer depth.
////////////////////////////////////////////////////////////

module wl_top import wl_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       host_req_valid_i,
  input  host_req_t  host_req_i,
  output logic       host_req_credit_o,
  input  logic       host_rsp_credit_i,
  output logic       host_rsp_valid_o,
  output host_rsp_t  host_rsp_o,
  input  logic       fetch_req_valid_i,
  input  addr_t      fetch_addr_i,
  output logic       fetch_credit_o,
  input  logic       fetch_rsp_credit_i,
  output logic       fetch_rsp_valid_o,
  output fetch_rsp_t fetch_rsp_o,
  output data_t      eoc_o
);

  logic      host_req_valid;
  host_req_t host_req;
  logic      host_req_pop;

  logic  fetch_valid;
  addr_t fetch_addr;
  logic  fetch_pop;

  host_req_t imem_req, dmem_req, csr_req;
  logic      imem_strb, dmem_strb, csr_strb;
  tgt_rsp_t  imem_rsp, dmem_rsp, csr_rsp;

  ////////////////////////////////////////////////////////////
  // Receive buffers
  ////////////////////////////////////////////////////////////

  credit_rx_fifo #(
    .payload_t ( host_req_t   ),
    .Depth     ( HostReqDepth )
  ) i_host_rx_fifo (
    .clk_i    ( clk_i             ),
    .reset_i  ( reset_i           ),
    .push_i   ( host_req_valid_i  ),
    .data_i   ( host_req_i        ),
    .credit_o ( host_req_credit_o ),
    .valid_o  ( host_req_valid    ),
    .data_o   ( host_req          ),
    .pop_i    ( host_req_pop      )
  );

  credit_rx_fifo #(
    .payload_t ( addr_t        ),
    .Depth     ( FetchReqDepth )
  ) i_fetch_rx_fifo (
    .clk_i    ( clk_i             ),
    .reset_i  ( reset_i           ),
    .push_i   ( fetch_req_valid_i ),
    .data_i   ( fetch_addr_i      ),
    .credit_o ( fetch_credit_o    ),
    .valid_o  ( fetch_valid       ),
    .data_o   ( fetch_addr        ),
    .pop_i    ( fetch_pop         )
  );

  ////////////////////////////////////////////////////////////
  // Host routing and targets
  ////////////////////////////////////////////////////////////

  bus_decoder i_bus_decoder (
    .clk_i        ( clk_i             ),
    .reset_i      ( reset_i           ),
    .req_valid_i  ( host_req_valid    ),
    .req_i        ( host_req          ),
    .req_pop_o    ( host_req_pop      ),
    .imem_req_o   ( imem_req          ),
    .dmem_req_o   ( dmem_req          ),
    .csr_req_o    ( csr_req           ),
    .imem_strb_o  ( imem_strb         ),
    .dmem_strb_o  ( dmem_strb         ),
    .csr_strb_o   ( csr_strb          ),
    .imem_rsp_i   ( imem_rsp          ),
    .dmem_rsp_i   ( dmem_rsp          ),
    .csr_rsp_i    ( csr_rsp           ),
    .rsp_credit_i ( host_rsp_credit_i ),
    .rsp_valid_o  ( host_rsp_valid_o  ),
    .rsp_o        ( host_rsp_o        )
  );

  instr_mem i_instr_mem (
    .clk_i              ( clk_i              ),
    .reset_i            ( reset_i            ),
    .fetch_valid_i      ( fetch_valid        ),
    .fetch_addr_i       ( fetch_addr         ),
    .fetch_pop_o        ( fetch_pop          ),
    .fetch_rsp_credit_i ( fetch_rsp_credit_i ),
    .fetch_rsp_valid_o  ( fetch_rsp_valid_o  ),
    .fetch_rsp_o        ( fetch_rsp_o        ),
    .host_strb_i        ( imem_strb          ),
    .host_req_i         ( imem_req           ),
    .host_rsp_o         ( imem_rsp           )
  );

  data_mem i_data_mem (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .strb_i  ( dmem_strb ),
    .req_i   ( dmem_req  ),
    .rsp_o   ( dmem_rsp  )
  );

  csr_regfile i_csr_regfile (
    .clk_i   ( clk_i    ),
    .reset_i ( reset_i  ),
    .strb_i  ( csr_strb ),
    .req_i   ( csr_req  ),
    .rsp_o   ( csr_rsp  ),
    .eoc_o   ( eoc_o    )
  );

endmodule

// ==== wl_top_sva.sv ====
////////////////////////////////////////////////////////////
// Credit and fetch address assertions, bound into wl_top.
// Counters start at zero on reset, like the DUT credit counts.
////////////////////////////////////////////////////////////

module wl_top_sva import wl_pkg::*; (
  input logic  clk_i,
  input logic  reset_i,
  input logic  host_req_valid_i,
  input logic  host_req_credit_o,
  input logic  host_rsp_credit_i,
  input logic  host_rsp_valid_o,
  input logic  fetch_req_valid_i,
  input logic  fetch_credit_o,
  input logic  fetch_rsp_credit_i,
  input logic  fetch_rsp_valid_o,
  input logic  fetch_valid,
  input addr_t fetch_addr
);

  timeunit 1ns;
  timeprecision 1ps;

  // Requests held by the DUT and response credits granted to it
  int host_open_q, fetch_open_q, host_held_q, fetch_held_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      host_open_q  <= 0;
      fetch_open_q <= 0;
      host_held_q  <= 0;
      fetch_held_q <= 0;
    end else begin
      host_open_q  <= host_open_q + int'(host_req_valid_i) - int'(host_req_credit_o);
      fetch_open_q <= fetch_open_q + int'(fetch_req_valid_i) - int'(fetch_credit_o);
      host_held_q  <= host_held_q + int'(host_rsp_credit_i) - int'(host_rsp_valid_o);
      fetch_held_q <= fetch_held_q + int'(fetch_rsp_credit_i) - int'(fetch_rsp_valid_o);
    end
  end

  host_credit_bounded: assert property (@(posedge clk_i) disable iff (reset_i)
    host_req_credit_o |-> host_open_q > 0)
    else $error("Host request credit returned with no request held");

  fetch_credit_bounded: assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_credit_o |-> fetch_open_q > 0)
    else $error("Fetch request credit returned with no request held");

  host_rsp_has_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    host_rsp_valid_o |-> host_held_q > 0)
    else $error("Host response sent without a response credit");

  fetch_rsp_has_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_rsp_valid_o |-> fetch_held_q > 0)
    else $error("Fetch response sent without a response credit");

  // Fetch addresses must fall inside the instruction region
  fetch_addr_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_valid |-> (fetch_addr >= InstrMemBaseAddr) &&
                    (fetch_addr < InstrMemBaseAddr + InstrMemSize))
    else $error("Fetch address outside the instruction memory");

endmodule

bind wl_top wl_top_sva i_wl_top_sva (
  .clk_i              ( clk_i              ),
  .reset_i            ( reset_i            ),
  .host_req_valid_i   ( host_req_valid_i   ),
  .host_req_credit_o  ( host_req_credit_o  ),
  .host_rsp_credit_i  ( host_rsp_credit_i  ),
  .host_rsp_valid_o   ( host_rsp_valid_o   ),
  .fetch_req_valid_i  ( fetch_req_valid_i  ),
  .fetch_credit_o     ( fetch_credit_o     ),
  .fetch_rsp_credit_i ( fetch_rsp_credit_i ),
  .fetch_rsp_valid_o  ( fetch_rsp_valid_o  ),
  .fetch_valid        ( fetch_valid        ),
  .fetch_addr         ( fetch_addr         )
);

// ==== tb_wl_top.sv ====
////////////////////////////////////////////////////////////
// Testbench for wl_top, stimulus and expectations from wl_stim.txt.
// Stimulus words per line: test, op, addr, wdata, exp data, exp err.
// Response credits are granted at pseudo-random cycles.
////////////////////////////////////////////////////////////

module tb_wl_top import wl_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int StimWords  = 6 * 64;
  localparam int WaitLimit  = 2000;
  localparam int HoldWindow = 24;

  // Stimulus operation codes
  localparam logic [7:0] OpWrite   = 8'h00;
  localparam logic [7:0] OpRead    = 8'h01;
  localparam logic [7:0] OpFetch   = 8'h02;
  localparam logic [7:0] OpEoc     = 8'h03;
  localparam logic [7:0] OpHold    = 8'h04;
  localparam logic [7:0] OpRelease = 8'h05;
  localparam logic [7:0] OpSync    = 8'h06;
  localparam logic [7:0] OpEnd     = 8'hff;

  logic       clk_i;
  logic       reset_i;
  logic       host_req_valid_i;
  host_req_t  host_req_i;
  logic       host_req_credit_o;
  logic       host_rsp_credit_i;
  logic       host_rsp_valid_o;
  host_rsp_t  host_rsp_o;
  logic       fetch_req_valid_i;
  addr_t      fetch_addr_i;
  logic       fetch_credit_o;
  logic       fetch_rsp_credit_i;
  logic       fetch_rsp_valid_o;
  fetch_rsp_t fetch_rsp_o;
  data_t      eoc_o;

  logic [31:0] stim_mem [StimWords];

  // Pending requests and expected responses, in order
  host_req_t  host_q[$];
  addr_t      fetch_q[$];
  host_rsp_t  host_exp_q[$];
  fetch_rsp_t fetch_exp_q[$];

  int          host_credits, fetch_credits;
  int          host_sent, fetch_sent, host_pulses, fetch_pulses;
  int          host_granted, host_got, fetch_granted, fetch_got;
  int          errors, test_errors, checks, tests_run, hold_rsp_seen;
  logic        withhold;
  logic [31:0] lfsr_q;
  logic        host_bit, fetch_bit;

  wl_top i_wl_top (
    .clk_i              ( clk_i              ),
    .reset_i            ( reset_i            ),
    .host_req_valid_i   ( host_req_valid_i   ),
    .host_req_i         ( host_req_i         ),
    .host_req_credit_o  ( host_req_credit_o  ),
    .host_rsp_credit_i  ( host_rsp_credit_i  ),
    .host_rsp_valid_o   ( host_rsp_valid_o   ),
    .host_rsp_o         ( host_rsp_o         ),
    .fetch_req_valid_i  ( fetch_req_valid_i  ),
    .fetch_addr_i       ( fetch_addr_i       ),
    .fetch_credit_o     ( fetch_credit_o     ),
    .fetch_rsp_credit_i ( fetch_rsp_credit_i ),
    .fetch_rsp_valid_o  ( fetch_rsp_valid_o  ),
    .fetch_rsp_o        ( fetch_rsp_o        ),
    .eoc_o              ( eoc_o              )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks and reporting
  ////////////////////////////////////////////////////////////

  task automatic check_host_rsp(input host_rsp_t got, input host_rsp_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0d ns: host response data %h error %b, expected data %h error %b",
               $time, got.rdata, got.error, exp.rdata, exp.error);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_fetch_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0d ns: fetch response %h, expected %h", $time, got.instr, exp.instr);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_eoc(input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0d ns: eoc_o is %h, expected %h", $time, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic finish_run();
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0d ns while waiting for %s", $time, what);
    errors++;
    finish_run();
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers, credit grants and monitors
  ////////////////////////////////////////////////////////////

  // One request per held credit
  always @(posedge clk_i) begin
    if (!reset_i && host_q.size() > 0 && host_credits > 0) begin
      host_req_valid_i <= 1'b1;
      host_req_i       <= host_q.pop_front();
      host_credits--;
      host_sent++;
    end else begin
      host_req_valid_i <= 1'b0;
    end
    if (!reset_i && fetch_q.size() > 0 && fetch_credits > 0) begin
      fetch_req_valid_i <= 1'b1;
      fetch_addr_i      <= fetch_q.pop_front();
      fetch_credits--;
      fetch_sent++;
    end else begin
      fetch_req_valid_i <= 1'b0;
    end
  end

  // Never grant more credits than responses still expected
  always @(posedge clk_i) begin
    lfsr_q    = lfsr_next(lfsr_q);
    host_bit  = lfsr_q[0];
    lfsr_q    = lfsr_next(lfsr_q);
    fetch_bit = lfsr_q[0];
    if (!reset_i && !withhold && host_bit && (host_granted - host_got < host_exp_q.size())) begin
      host_rsp_credit_i <= 1'b1;
      host_granted++;
    end else begin
      host_rsp_credit_i <= 1'b0;
    end
    if (!reset_i && fetch_bit && (fetch_granted - fetch_got < fetch_exp_q.size())) begin
      fetch_rsp_credit_i <= 1'b1;
      fetch_granted++;
    end else begin
      fetch_rsp_credit_i <= 1'b0;
    end
  end

  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (host_req_credit_o) begin
        host_credits++;
        host_pulses++;
      end
      if (fetch_credit_o) begin
        fetch_credits++;
        fetch_pulses++;
      end
      if (host_rsp_valid_o) begin
        host_got++;
        if (withhold) begin
          hold_rsp_seen++;
        end
        if (host_exp_q.size() == 0) begin
          report_problem("Host response arrived with no request outstanding");
        end else begin
          check_host_rsp(host_rsp_o, host_exp_q.pop_front());
        end
      end
      if (fetch_rsp_valid_o) begin
        fetch_got++;
        if (fetch_exp_q.size() == 0) begin
          report_problem("Fetch response arrived with no fetch outstanding");
        end else begin
          check_fetch_rsp(fetch_rsp_o, fetch_exp_q.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////

  task automatic drain_all();
    int n;
    n = 0;
    while (host_q.size() != 0 || fetch_q.size() != 0 ||
           host_exp_q.size() != 0 || fetch_exp_q.size() != 0) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) begin
        abort_on_timeout("outstanding responses");
      end
    end
  endtask

  // Nothing may move before the first request
  task automatic check_idle();
    repeat (8) @(negedge clk_i);
    if (host_pulses != 0 || fetch_pulses != 0 || host_got != 0 || fetch_got != 0) begin
      report_problem("Credit pulse or response seen before the first request");
    end
  endtask

  task automatic release_credits();
    int n;
    n = 0;
    while (host_q.size() != 0) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) begin
        abort_on_timeout("host requests to be sent while credits are withheld");
      end
    end
    repeat (HoldWindow) @(negedge clk_i);
    if (hold_rsp_seen != 0) begin
      report_problem("Host response sent while response credits were withheld");
    end
    withhold = 1'b0;
  endtask

  task automatic finish_test(input int test_num);
    int n;
    drain_all();
    n = 0;
    while ((host_pulses != host_sent || fetch_pulses != fetch_sent) && n < 16) begin
      @(negedge clk_i);
      n++;
    end
    if (host_pulses != host_sent || fetch_pulses != fetch_sent) begin
      report_problem("Request credit pulses do not match the requests sent");
    end
    tests_run++;
    $display("Test %0d finished with %0d errors", test_num, test_errors);
    test_errors = 0;
  endtask

  task automatic apply_op(input logic [7:0] op, input addr_t addr, input data_t wdata,
                          input data_t exp_data, input logic exp_err);
    host_req_t  req;
    host_rsp_t  rsp;
    fetch_rsp_t frsp;
    req.addr   = addr;
    req.write  = (op == OpWrite);
    req.wdata  = (op == OpWrite) ? wdata : '0;
    rsp.rdata  = exp_data;
    rsp.error  = exp_err;
    frsp.instr = exp_data;
    case (op)
      OpWrite, OpRead: begin
        host_q.push_back(req);
        host_exp_q.push_back(rsp);
      end
      OpFetch: begin
        fetch_q.push_back(addr);
        fetch_exp_q.push_back(frsp);
      end
      OpEoc: begin
        drain_all();
        check_eoc(eoc_o, exp_data);
      end
      OpHold: begin
        drain_all();
        hold_rsp_seen = 0;
        withhold      = 1'b1;
      end
      OpRelease: release_credits();
      OpSync:    drain_all();
      default:   report_problem("Unknown operation code in the stimulus file");
    endcase
  endtask

  initial begin
    int         idx;
    int         cur_test;
    logic [7:0] op;
    reset_i            = 1'b1;
    host_req_valid_i   = 1'b0;
    host_req_i         = '0;
    host_rsp_credit_i  = 1'b0;
    fetch_req_valid_i  = 1'b0;
    fetch_addr_i       = '0;
    fetch_rsp_credit_i = 1'b0;
    lfsr_q             = 32'h3f4b;
    withhold           = 1'b0;
    host_credits       = HostReqDepth;
    fetch_credits      = FetchReqDepth;
    $readmemh("wl_stim.txt", stim_mem);

    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    check_idle();

    idx      = 0;
    cur_test = int'(stim_mem[0]);
    while (idx + 5 < StimWords) begin
      op = stim_mem[idx+1][7:0];
      if (op === OpEnd || $isunknown(op) || int'(stim_mem[idx]) != cur_test) begin
        finish_test(cur_test);
        if (op === OpEnd || $isunknown(op)) begin
          break;
        end
        cur_test = int'(stim_mem[idx]);
      end
      apply_op(op, stim_mem[idx+2], stim_mem[idx+3], stim_mem[idx+4], stim_mem[idx+5][0]);
      idx += 6;
    end
    finish_run();
  end

endmodule

// ==== wl_stim.txt ====
// Columns (hex): test op addr wdata exp_data exp_err
// Ops: 0 write, 1 read, 2 fetch, 3 eoc check, 4 hold, 5 release, 6 sync, ff end
1 3 00000000 00000000 00000000 0
2 0 00002000 a5a50001 00000000 0
2 0 00002004 5a5a0002 00000000 0
2 0 000023fc deadbeef 00000000 0
2 1 00002000 00000000 a5a50001 0
2 1 00002004 00000000 5a5a0002 0
2 1 000023fc 00000000 deadbeef 0
3 0 00001000 00000013 00000000 0
3 0 00001004 00100093 00000000 0
3 0 00001008 00208113 00000000 0
3 0 000013fc 0000006f 00000000 0
3 6 00000000 00000000 00000000 0
3 2 00001000 00000000 00000013 0
3 1 00001004 00000000 00100093 0
3 2 00001004 00000000 00100093 0
3 2 00001008 00000000 00208113 0
3 1 000013fc 00000000 0000006f 0
3 2 000013fc 00000000 0000006f 0
3 1 00001000 00000000 00000013 0
4 0 00003004 11110001 00000000 0
4 0 00003008 22220002 00000000 0
4 0 0000300c 33330003 00000000 0
4 0 00003000 00000001 00000000 0
4 3 00000000 00000000 00000001 0
4 1 00003000 00000000 00000001 0
4 1 00003004 00000000 11110001 0
4 1 00003008 00000000 22220002 0
4 1 0000300c 00000000 33330003 0
5 1 00000000 00000000 00000000 1
5 0 00000000 12345678 00000000 1
5 1 00004000 00000000 00000000 1
5 0 00004000 87654321 00000000 1
5 1 00003010 00000000 00000000 1
5 0 00001400 0badf00d 00000000 1
6 4 00000000 00000000 00000000 0
6 0 00002010 600d0006 00000000 0
6 1 00002010 00000000 600d0006 0
6 1 00003004 00000000 11110001 0
6 5 00000000 00000000 00000000 0
6 1 00004000 00000000 00000000 1
ff ff 00000000 00000000 00000000 0

// ==== sources.f ====
wl_pkg.sv
credit_rx_fifo.sv
bus_decoder.sv
instr_mem.sv
data_mem.sv
csr_regfile.sv
wl_top.sv
wl_top_sva.sv
tb_wl_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the wl_top testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sources.f --top-module tb_wl_top -o sim_tb_wl_top

./obj_dir/sim_tb_wl_top | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation finished without failures"
